/* Makefile */
VERILATOR ?= verilator
TOP       ?= opm_tb
LOG       ?= sim.log
SEED      ?= 120
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "override: TOP=$(TOP) LOG=$(LOG) SEED=$(SEED) OBJ_DIR=$(OBJ_DIR)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "no result found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/opm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opm_cfg.svh"

module opm_tb;

    localparam int CLK_NS    = 100;
    localparam int RST_CYC   = 10;
    localparam int FRAME_CYC = 2 * `OPM_SLOTS;  // phiM enabled every cycle

    // timer control register 0x14
    localparam logic [7:0] RUN_A  = 8'h01;
    localparam logic [7:0] RUN_B  = 8'h02;
    localparam logic [7:0] IRQ_A  = 8'h04;
    localparam logic [7:0] IRQ_B  = 8'h08;
    localparam logic [7:0] FRST_A = 8'h10;
    localparam logic [7:0] FRST_B = 8'h20;

    logic       i_emuclk;
    logic       i_arst_n;
    logic       i_phim_pcen_n;
    logic       i_cs_n;
    logic       i_rd_n;
    logic       i_wr_n;
    logic       i_a0;
    logic [7:0] i_d;
    logic [7:0] o_d;
    logic       o_d_oe;
    logic       o_phi1;
    logic       o_ct1;
    logic       o_ct2;
    logic       o_irq_n;

    string test_name;
    int    test_errs;
    int    tests_run;
    int    tests_failed;
    int    limit_cycles;
    int    meas_exp;
    logic  meas_on;
    logic  meas_done;
    time   fall_times[$];

    opm_top opm_top_inst (
        .i_emuclk       (i_emuclk),
        .i_arst_n       (i_arst_n),
        .i_phim_pcen_n  (i_phim_pcen_n),
        .i_cs_n         (i_cs_n),
        .i_rd_n         (i_rd_n),
        .i_wr_n         (i_wr_n),
        .i_a0           (i_a0),
        .i_d            (i_d),
        .o_d            (o_d),
        .o_d_oe         (o_d_oe),
        .o_phi1         (o_phi1),
        .o_ct1          (o_ct1),
        .o_ct2          (o_ct2),
        .o_irq_n        (o_irq_n)
    );

    initial begin
        i_emuclk = 1'b0;
        forever #(CLK_NS / 2) i_emuclk = ~i_emuclk;
    end

    // flag interval in clock cycles
    function automatic int expected_period(input logic timer_b, input int preset);
        if (timer_b) begin
            return ((1 << `OPM_TMRB_W) - preset) * `OPM_TMRB_DIV * FRAME_CYC;
        end
        return ((1 << `OPM_TMRA_W) - preset) * FRAME_CYC;
    endfunction

    ////////////////////
    // checking
    ////////////////////

    task automatic check_eq(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("error in test %s: %s", test_name, msg);
        test_errs++;
    endtask

    // irq falls are timestamped, the first two give the interval
    always @(negedge o_irq_n) begin
        if (meas_on && !meas_done) begin
            fall_times.push_back($time);
            if (fall_times.size() == 2) begin
                check_eq("flag interval", meas_exp,
                         int'((fall_times[1] - fall_times[0]) / CLK_NS));
                meas_done = 1'b1;
            end
        end
    end

    task automatic arm_interval(input int exp);
        fall_times.delete();
        meas_exp  = exp;
        meas_done = 1'b0;
        meas_on   = 1'b1;
    endtask

    task automatic wait_falls(input int n, input int max_cyc);
        int cyc;
        cyc = 0;
        while (fall_times.size() < n && cyc < max_cyc) begin
            @(negedge i_emuclk);
            cyc++;
        end
        if (fall_times.size() < n)
            note_error($sformatf("fewer than %0d o_irq_n falls in %0d cycles", n, max_cyc));
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errs);
        end
    endtask

    ////////////////////
    // bus access
    ////////////////////

    task automatic strobe_write(input logic a0, input logic [7:0] d);
        @(negedge i_emuclk);
        i_cs_n = 1'b0;
        i_a0   = a0;
        i_d    = d;
        i_wr_n = 1'b0;
        repeat (2) @(negedge i_emuclk);
        i_wr_n = 1'b1;
        i_cs_n = 1'b1;
        @(negedge i_emuclk);
    endtask

    task automatic read_status(output logic [7:0] st);
        @(negedge i_emuclk);
        i_cs_n = 1'b0;
        i_rd_n = 1'b0;
        @(negedge i_emuclk);
        if (!o_d_oe)
            note_error("o_d_oe low during a status read");
        st     = o_d;
        i_cs_n = 1'b1;
        i_rd_n = 1'b1;
    endtask

    task automatic wait_not_busy(output int cycles);
        logic [7:0] st;
        time        t0;
        t0 = $time;
        read_status(st);
        while (st[7] && ($time - t0) < 4 * FRAME_CYC * CLK_NS) begin
            read_status(st);
        end
        if (st[7])
            note_error("busy flag never cleared");
        cycles = int'(($time - t0) / CLK_NS);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        int cyc;
        strobe_write(1'b0, addr);
        wait_not_busy(cyc);
        strobe_write(1'b1, data);
    endtask

    ////////////////////
    // watchdog
    ////////////////////

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge i_emuclk);
        $display("watchdog expired after %0d cycles, run stopped", limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        logic [7:0] st;
        logic [7:0] v;
        logic       phi1_prev;
        int         cyc;
        int         clka;
        int         per_a;
        int         per_b;
        int         low_cyc;

        i_arst_n      = 1'b0;
        i_phim_pcen_n = 1'b0;
        i_cs_n        = 1'b1;
        i_rd_n        = 1'b1;
        i_wr_n        = 1'b1;
        i_a0          = 1'b0;
        i_d           = 8'h00;
        meas_on       = 1'b0;
        meas_done     = 1'b0;
        void'($urandom(32'h78));

        clka  = 1000 + int'($urandom % 21);
        per_a = expected_period(1'b0, clka);
        per_b = expected_period(1'b1, 252);
        limit_cycles = 3 * (per_a + per_b + 3 * per_a) + 10000;

        repeat (RST_CYC) @(negedge i_emuclk);
        i_arst_n = 1'b1;
        repeat (4) @(negedge i_emuclk);

        start_test("reset");
        check_eq("o_d_oe idle", 0, int'(o_d_oe));
        // phiM enabled every cycle, so phi1 flips each clock
        for (int i = 0; i < 4; i++) begin
            phi1_prev = o_phi1;
            @(negedge i_emuclk);
            check_eq("o_phi1 toggle", int'(!phi1_prev), int'(o_phi1));
        end
        read_status(st);
        check_eq("status", 0, int'(st));
        check_eq("o_irq_n", 1, int'(o_irq_n));
        check_eq("o_ct1", 0, int'(o_ct1));
        check_eq("o_ct2", 0, int'(o_ct2));
        end_test();

        start_test("busy");
        bus_write(8'h08, 8'h00);    // unused address
        wait_not_busy(cyc);         // lands just after a frame tick
        bus_write(8'h08, 8'h5A);
        read_status(st);
        check_eq("status bit 7 after write", 1, int'(st[7]));
        wait_not_busy(cyc);
        // the polling read itself adds a few cycles
        if (cyc > FRAME_CYC + 4) begin
            $display("[FAIL] %s busy cycles: expected <= %0d, actual %0d",
                     test_name, FRAME_CYC + 4, cyc);
            test_errs++;
        end
        end_test();

        start_test("ct_pins");
        for (int i = 0; i < 4; i++) begin
            v = 8'($urandom);
            bus_write(8'h1B, v);
            wait_not_busy(cyc);
            repeat (2) @(negedge i_emuclk);
            check_eq("o_ct2", int'(v[7]), int'(o_ct2));
            check_eq("o_ct1", int'(v[6]), int'(o_ct1));
        end
        end_test();

        start_test("timer_a");
        bus_write(8'h10, 8'(clka >> 2));
        bus_write(8'h11, 8'(clka & 3));
        arm_interval(per_a);
        bus_write(8'h14, RUN_A | IRQ_A);
        wait_falls(1, per_a + 4 * FRAME_CYC);
        bus_write(8'h14, RUN_A | IRQ_A | FRST_A);
        wait_falls(2, per_a + 4 * FRAME_CYC);
        meas_on = 1'b0;
        read_status(st);
        check_eq("status flags", 1, int'(st[1:0]));
        end_test();

        start_test("timer_b");
        bus_write(8'h14, FRST_A);   // stop A and drop its flag
        bus_write(8'h12, 8'd252);
        arm_interval(per_b);
        bus_write(8'h14, RUN_B | IRQ_B);
        wait_falls(1, per_b + 20 * FRAME_CYC);
        bus_write(8'h14, RUN_B | IRQ_B | FRST_B);
        wait_falls(2, per_b + 4 * FRAME_CYC);
        meas_on = 1'b0;
        read_status(st);
        check_eq("status flags", 2, int'(st[1:0]));
        end_test();

        start_test("flag_reset");
        bus_write(8'h14, FRST_B);
        wait_not_busy(cyc);
        arm_interval(per_a);
        bus_write(8'h14, RUN_A | IRQ_A);
        wait_falls(1, per_a + 4 * FRAME_CYC);
        meas_on = 1'b0;
        read_status(st);
        check_eq("status flags set", 1, int'(st[1:0]));
        check_eq("o_irq_n while flagged", 0, int'(o_irq_n));
        bus_write(8'h14, RUN_A | IRQ_A | FRST_A);
        wait_not_busy(cyc);
        repeat (4) @(negedge i_emuclk);     // reg, flag, irq stages
        read_status(st);
        check_eq("status flags cleared", 0, int'(st[1:0]));
        check_eq("o_irq_n after reset", 1, int'(o_irq_n));
        // keep A running with its irq enable off
        bus_write(8'h14, RUN_A | FRST_A);
        wait_not_busy(cyc);
        repeat (4) @(negedge i_emuclk);
        low_cyc = 0;
        repeat (2 * per_a + 2 * FRAME_CYC) begin
            @(negedge i_emuclk);
            if (!o_irq_n)
                low_cyc++;
        end
        check_eq("o_irq_n low cycles", 0, low_cyc);
        read_status(st);
        check_eq("status flags masked", 0, int'(st[1:0]));
        bus_write(8'h14, 8'h00);
        end_test();

        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hw
hw/opm_pkg.sv
hw/opm_timing_gen.sv
hw/opm_bus_if.sv
hw/opm_reg_block.sv
hw/opm_timer.sv
hw/opm_top.sv
bench/opm_tb.sv

/* hw/opm_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opm_cfg.svh"

module opm_bus_if (
    input  logic                   i_emuclk,
    input  logic                   i_rst_n,
    input  opm_pkg::opm_bus_t      i_bus,
    input  logic                   i_frame_tick,
    input  logic                   i_flag_a,
    input  logic                   i_flag_b,
    output opm_pkg::opm_wr_t       o_wr,
    output logic [`OPM_DATA_W-1:0] o_d,
    output logic                   o_d_oe
);

    localparam opm_pkg::opm_bus_t BUS_IDLE = '{
        cs_n: 1'b1,
        rd_n: 1'b1,
        wr_n: 1'b1,
        a0:   1'b0,
        d:    '0
    };

    opm_pkg::opm_bus_t      bus_q1;
    opm_pkg::opm_bus_t      bus_q2;
    opm_pkg::opm_wr_state_e state;
    logic                   wr_fall;
    logic                   busy;
    logic                   wr_valid;
    logic [`OPM_ADDR_W-1:0] addr_lat;
    logic [`OPM_ADDR_W-1:0] pend_addr;
    logic [`OPM_DATA_W-1:0] data_lat;

    ////////////////////
    // strobe sampling
    ////////////////////

    always_ff @(posedge i_emuclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bus_q1 <= BUS_IDLE;
            bus_q2 <= BUS_IDLE;
        end else begin
            bus_q1 <= i_bus;
            bus_q2 <= bus_q1;
        end
    end

    assign wr_fall = bus_q2.wr_n & ~bus_q1.wr_n & ~bus_q1.cs_n;

    ////////////////////
    // latches
    ////////////////////

    always_ff @(posedge i_emuclk) begin
        if (wr_fall && !bus_q1.a0) begin
            addr_lat <= bus_q1.d;
        end
        // a write made while busy is dropped
        if (wr_fall && bus_q1.a0 && state == opm_pkg::IDLE) begin
            pend_addr <= addr_lat;  // later address writes must not move it
            data_lat  <= bus_q1.d;
        end
    end

    // held until the next frame boundary
    always_ff @(posedge i_emuclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= opm_pkg::IDLE;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;
            case (state)
                opm_pkg::IDLE: begin
                    if (wr_fall && bus_q1.a0) begin
                        state <= opm_pkg::PENDING;
                    end
                end
                opm_pkg::PENDING: begin
                    if (i_frame_tick) begin
                        state    <= opm_pkg::IDLE;
                        wr_valid <= 1'b1;
                    end
                end
                default: state <= opm_pkg::IDLE;
            endcase
        end
    end

    assign busy = (state == opm_pkg::PENDING);

    assign o_wr.valid = wr_valid;
    assign o_wr.addr  = pend_addr;
    assign o_wr.data  = data_lat;

    // status byte
    assign o_d    = {busy, {(`OPM_DATA_W - 3){1'b0}}, i_flag_b, i_flag_a};
    assign o_d_oe = ~bus_q1.cs_n & ~bus_q1.rd_n;

    a_commit_single : assert property (
        @(posedge i_emuclk) disable iff (!i_rst_n)
        o_wr.valid |=> !o_wr.valid
    ) else $error("register write held for two cycles");

endmodule

`default_nettype wire

/* hw/opm_cfg.svh */
`ifndef OPM_CFG_SVH
`define OPM_CFG_SVH

////////////////////
// frame structure
////////////////////

// slots in one sample frame
`define OPM_SLOTS       32

////////////////////
// timers
////////////////////

`define OPM_TMRA_W      10  // timer A, CLKA1 + CLKA2
`define OPM_TMRB_W      8   // timer B, CLKB
`define OPM_TMRB_DIV    16  // frames per timer B tick

////////////////////
// cpu bus
////////////////////

`define OPM_ADDR_W      8   // register address space
`define OPM_DATA_W      8   // bus data width

`endif

/* hw/opm_pkg.sv */
`default_nettype none

`include "opm_cfg.svh"

package opm_pkg;

    // pins as seen after the sampling flops
    typedef struct packed {
        logic                   cs_n;
        logic                   rd_n;
        logic                   wr_n;
        logic                   a0;
        logic [`OPM_DATA_W-1:0] d;
    } opm_bus_t;

    // one register write, released at a frame boundary
    typedef struct packed {
        logic                   valid;
        logic [`OPM_ADDR_W-1:0] addr;
        logic [`OPM_DATA_W-1:0] data;
    } opm_wr_t;

    typedef struct packed {
        logic run;
        logic irq_en;
        logic flag_rst;     // single-cycle pulse
    } opm_tmr_ctrl_t;

    typedef enum logic [`OPM_ADDR_W-1:0] {
        REG_CLKA_HI  = 'h10,    // CLKA bits 9..2
        REG_CLKA_LO  = 'h11,    // CLKA bits 1..0
        REG_CLKB     = 'h12,
        REG_TMR_CTRL = 'h14,
        REG_CT       = 'h1B
    } opm_reg_addr_e;

    typedef enum logic {
        IDLE    = 1'b0,
        PENDING = 1'b1
    } opm_wr_state_e;

endpackage

`default_nettype wire

/* hw/opm_reg_block.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opm_cfg.svh"

module opm_reg_block (
    input  logic                   i_emuclk,
    input  logic                   i_rst_n,
    input  opm_pkg::opm_wr_t       i_wr,
    output logic [`OPM_TMRA_W-1:0] o_clka,
    output logic [`OPM_TMRB_W-1:0] o_clkb,
    output opm_pkg::opm_tmr_ctrl_t o_ctrl_a,
    output opm_pkg::opm_tmr_ctrl_t o_ctrl_b,
    output logic                   o_ct1,
    output logic                   o_ct2
);

    localparam int CLKA_LO_W = `OPM_TMRA_W - `OPM_DATA_W;

    opm_pkg::opm_reg_addr_e addr;
    logic [`OPM_DATA_W-1:0] clka_hi;
    logic [CLKA_LO_W-1:0]   clka_lo;
    logic [`OPM_TMRB_W-1:0] clkb;
    logic                   run_a;
    logic                   run_b;
    logic                   irq_en_a;
    logic                   irq_en_b;
    logic                   frst_a;
    logic                   frst_b;

    assign addr = opm_pkg::opm_reg_addr_e'(i_wr.addr);

    ////////////////////
    // register decode
    ////////////////////

    always_ff @(posedge i_emuclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clka_hi  <= '0;
            clka_lo  <= '0;
            clkb     <= '0;
            run_a    <= 1'b0;
            run_b    <= 1'b0;
            irq_en_a <= 1'b0;
            irq_en_b <= 1'b0;
            frst_a   <= 1'b0;
            frst_b   <= 1'b0;
            o_ct1    <= 1'b0;
            o_ct2    <= 1'b0;
        end else begin
            frst_a <= 1'b0;     // flag resets last one cycle
            frst_b <= 1'b0;
            if (i_wr.valid) begin
                case (addr)
                    opm_pkg::REG_CLKA_HI: clka_hi <= i_wr.data;
                    opm_pkg::REG_CLKA_LO: clka_lo <= i_wr.data[CLKA_LO_W-1:0];
                    opm_pkg::REG_CLKB:    clkb    <= i_wr.data[`OPM_TMRB_W-1:0];
                    opm_pkg::REG_TMR_CTRL: begin
                        run_a    <= i_wr.data[0];
                        run_b    <= i_wr.data[1];
                        irq_en_a <= i_wr.data[2];
                        irq_en_b <= i_wr.data[3];
                        frst_a   <= i_wr.data[4];
                        frst_b   <= i_wr.data[5];
                    end
                    opm_pkg::REG_CT: begin
                        o_ct2 <= i_wr.data[7];  // pin 8
                        o_ct1 <= i_wr.data[6];  // pin 9
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    ////////////////////
    // outputs
    ////////////////////

    // 0x10 is the high part of CLKA
    assign o_clka = {clka_hi, clka_lo};
    assign o_clkb = clkb;

    assign o_ctrl_a = '{run: run_a, irq_en: irq_en_a, flag_rst: frst_a};
    assign o_ctrl_b = '{run: run_b, irq_en: irq_en_b, flag_rst: frst_b};

endmodule

`default_nettype wire

/* hw/opm_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module opm_timer #(
    parameter int WIDTH = 10,
    parameter int DIV   = 1     // frames per count
) (
    input  logic                   i_emuclk,
    input  logic                   i_rst_n,
    input  logic                   i_frame_tick,
    input  logic [WIDTH-1:0]       i_preset,
    input  opm_pkg::opm_tmr_ctrl_t i_ctrl,
    output logic                   o_flag
);

    localparam int PSC_W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [PSC_W-1:0] psc;
    logic             tick;
    logic             run_q;
    logic             counting;
    logic             load_pend;
    logic             ovfl;
    logic [WIDTH-1:0] cnt;

    ////////////////////
    // prescaler
    ////////////////////

    // free running, so the tick phase does not depend on run
    always_ff @(posedge i_emuclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            psc <= '0;
        end else if (i_frame_tick) begin
            if (psc == PSC_W'(DIV - 1)) begin
                psc <= '0;
            end else begin
                psc <= psc + 1'b1;
            end
        end
    end

    assign tick = i_frame_tick & (psc == PSC_W'(DIV - 1));

    ////////////////////
    // counter
    ////////////////////

    // skip the cycle where run rises
    assign counting = i_ctrl.run & run_q;
    assign ovfl     = tick & counting & ~load_pend & (&cnt);

    always_ff @(posedge i_emuclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_q     <= 1'b0;
            load_pend <= 1'b0;
            cnt       <= '0;
        end else begin
            run_q <= i_ctrl.run;
            if (!i_ctrl.run) begin
                load_pend <= 1'b0;
            end else if (!run_q) begin
                load_pend <= 1'b1;  // preset goes in on the next tick
            end else if (tick) begin
                load_pend <= 1'b0;
            end

            if (counting && tick) begin
                if (load_pend || (&cnt)) begin
                    cnt <= i_preset;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // flag
    ////////////////////

    always_ff @(posedge i_emuclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_flag <= 1'b0;
        end else if (ovfl && i_ctrl.irq_en) begin
            o_flag <= 1'b1;
        end else if (i_ctrl.flag_rst) begin
            o_flag <= 1'b0;
        end
    end

    a_hold_when_stopped : assert property (
        @(posedge i_emuclk) disable iff (!i_rst_n)
        !i_ctrl.run |=> $stable(cnt)
    ) else $error("timer counter moved while stopped");

endmodule

`default_nettype wire

/* hw/opm_timing_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opm_cfg.svh"

module opm_timing_gen (
    input  logic i_emuclk,
    input  logic i_arst_n,
    input  logic i_phim_pcen_n,     // active low
    output logic o_rst_n,
    output logic o_phi1,
    output logic o_phi1_en,
    output logic o_frame_tick
);

    localparam int SLOT_W = $clog2(`OPM_SLOTS);

    logic [1:0]        rst_sync;
    logic              phim_en;
    logic [SLOT_W-1:0] slot_cnt;

    ////////////////////
    // reset
    ////////////////////

    // async assert, release after two clocks
    always_ff @(posedge i_emuclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign o_rst_n = rst_sync[1];

    ////////////////////
    // phi1
    ////////////////////

    assign phim_en = ~i_phim_pcen_n;

    always_ff @(posedge i_emuclk or negedge o_rst_n) begin
        if (!o_rst_n) begin
            o_phi1 <= 1'b0;
        end else if (phim_en) begin
            o_phi1 <= ~o_phi1;  // half rate of phiM
        end
    end

    // one enable per phi1 period, where phi1 falls
    assign o_phi1_en = phim_en & o_phi1;

    ////////////////////
    // slot counter
    ////////////////////

    always_ff @(posedge i_emuclk or negedge o_rst_n) begin
        if (!o_rst_n) begin
            slot_cnt <= '0;
        end else if (o_phi1_en) begin
            if (slot_cnt == SLOT_W'(`OPM_SLOTS - 1)) begin
                slot_cnt <= '0;
            end else begin
                slot_cnt <= slot_cnt + 1'b1;
            end
        end
    end

    // end of slot 31
    assign o_frame_tick = o_phi1_en & (slot_cnt == SLOT_W'(`OPM_SLOTS - 1));

    // frame boundary lines up with a phi1 falling edge
    a_tick_on_phi1_fall : assert property (
        @(posedge i_emuclk) disable iff (!o_rst_n)
        o_frame_tick |=> $fell(o_phi1)
    ) else $error("frame tick not at a phi1 fall");

endmodule

`default_nettype wire

/* hw/opm_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opm_cfg.svh"

module opm_top (
    input  logic                   i_emuclk,
    input  logic                   i_arst_n,
    input  logic                   i_phim_pcen_n,
    input  logic                   i_cs_n,
    input  logic                   i_rd_n,
    input  logic                   i_wr_n,
    input  logic                   i_a0,
    input  logic [`OPM_DATA_W-1:0] i_d,
    output logic [`OPM_DATA_W-1:0] o_d,
    output logic                   o_d_oe,
    output logic                   o_phi1,
    output logic                   o_ct1,
    output logic                   o_ct2,
    output logic                   o_irq_n
);

    opm_pkg::opm_bus_t      bus;
    opm_pkg::opm_wr_t       wr;
    opm_pkg::opm_tmr_ctrl_t ctrl_a;
    opm_pkg::opm_tmr_ctrl_t ctrl_b;
    logic                   rst_n;
    logic                   frame_tick;
    logic                   flag_a;
    logic                   flag_b;
    logic [`OPM_TMRA_W-1:0] clka;
    logic [`OPM_TMRB_W-1:0] clkb;

    assign bus = '{cs_n: i_cs_n, rd_n: i_rd_n, wr_n: i_wr_n, a0: i_a0, d: i_d};

    ////////////////////
    // blocks
    ////////////////////

    opm_timing_gen timing_gen_inst (
        .i_emuclk       (i_emuclk),
        .i_arst_n       (i_arst_n),
        .i_phim_pcen_n  (i_phim_pcen_n),
        .o_rst_n        (rst_n),
        .o_phi1         (o_phi1),
        .o_phi1_en      (),
        .o_frame_tick   (frame_tick)
    );

    opm_bus_if bus_if_inst (
        .i_emuclk       (i_emuclk),
        .i_rst_n        (rst_n),
        .i_bus          (bus),
        .i_frame_tick   (frame_tick),
        .i_flag_a       (flag_a),
        .i_flag_b       (flag_b),
        .o_wr           (wr),
        .o_d            (o_d),
        .o_d_oe         (o_d_oe)
    );

    opm_reg_block reg_block_inst (
        .i_emuclk       (i_emuclk),
        .i_rst_n        (rst_n),
        .i_wr           (wr),
        .o_clka         (clka),
        .o_clkb         (clkb),
        .o_ctrl_a       (ctrl_a),
        .o_ctrl_b       (ctrl_b),
        .o_ct1          (o_ct1),
        .o_ct2          (o_ct2)
    );

    // timer A counts every frame
    opm_timer #(
        .WIDTH          (`OPM_TMRA_W),
        .DIV            (1)
    ) timer_a_inst (
        .i_emuclk       (i_emuclk),
        .i_rst_n        (rst_n),
        .i_frame_tick   (frame_tick),
        .i_preset       (clka),
        .i_ctrl         (ctrl_a),
        .o_flag         (flag_a)
    );

    opm_timer #(
        .WIDTH          (`OPM_TMRB_W),
        .DIV            (`OPM_TMRB_DIV)
    ) timer_b_inst (
        .i_emuclk       (i_emuclk),
        .i_rst_n        (rst_n),
        .i_frame_tick   (frame_tick),
        .i_preset       (clkb),
        .i_ctrl         (ctrl_b),
        .o_flag         (flag_b)
    );

    ////////////////////
    // interrupt
    ////////////////////

    always_ff @(posedge i_emuclk or negedge rst_n) begin
        if (!rst_n) begin
            o_irq_n <= 1'b1;
        end else begin
            o_irq_n <= ~(flag_a | flag_b);  // open drain on the real part
        end
    end

endmodule

`default_nettype wire
